/* l15_pkg.sv */
// L1.5 bridge encodings
`default_nettype none

package l15_pkg;

    // request types
    localparam logic [4:0] rq_load = 5'd0;
    localparam logic [4:0] rq_store = 5'd1;

    // return types
    localparam logic [3:0] ret_load = 4'd0;
    localparam logic [3:0] ret_st_ack = 4'd4;
    localparam logic [3:0] ret_int = 4'd7;

    // access size codes
    localparam logic [2:0] sz_1b = 3'd0;
    localparam logic [2:0] sz_2b = 3'd1;
    localparam logic [2:0] sz_4b = 3'd2;

    // interrupt kind carried in an interrupt return
    localparam logic [1:0] int_wakeup = 2'd1;

    // avalon word address bit marking non-cacheable space
    localparam int nc_bit = 29;

    // request FSM states
    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_issue_a = 3'd1;
    localparam logic [2:0] st_issue_b = 3'd2;
    localparam logic [2:0] st_wait_load = 3'd3;
    localparam logic [2:0] st_done = 3'd4;

    // first return data word read either as load lanes or as an interrupt
    typedef union packed {
        struct packed {
            logic [31:0] hi;
            logic [31:0] lo;
        } ld;
        struct packed {
            logic [45:0] pad_hi;
            logic [1:0] kind;
            logic [15:0] pad_lo;
        } intr;
    } l15_ret_word_t;

endpackage

`default_nettype wire

/* store_splitter.sv */
// Avalon write to L1.5 store pieces
`timescale 1ns/1ps
`default_nettype none

module store_splitter (
    input  logic        clk,
    input  logic        mem_write,
    input  logic [3:0]  byteenable,
    input  logic [31:0] writedata,
    input  logic [31:0] byte_base,
    output logic        two_pieces,
    output logic [2:0]  size_a,
    output logic [2:0]  size_b,
    output logic [31:0] addr_a,
    output logic [31:0] addr_b,
    output logic [63:0] data_a,
    output logic [63:0] data_b
);
    import l15_pkg::*;

    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [7:0]  b3;
    logic [1:0]  off_a;
    logic [1:0]  off_b;
    logic [31:0] word_a;
    logic [31:0] word_b;
    logic        legal;

    // byte lane k lives at byte_base + k
    assign b0 = writedata[7:0];
    assign b1 = writedata[15:8];
    assign b2 = writedata[23:16];
    assign b3 = writedata[31:24];

    always_comb begin
        two_pieces = 1'b0;
        legal = 1'b1;
        size_a = sz_1b;
        size_b = sz_1b;
        off_a = 2'd0;
        off_b = 2'd0;
        word_a = 32'd0;
        word_b = 32'd0;
        case (byteenable)
            4'b0001: word_a = {24'd0, b0};
            4'b0010: begin
                off_a = 2'd1;
                word_a = {24'd0, b1};
            end
            4'b0100: begin
                off_a = 2'd2;
                word_a = {24'd0, b2};
            end
            4'b1000: begin
                off_a = 2'd3;
                word_a = {24'd0, b3};
            end
            4'b0011: begin
                size_a = sz_2b;
                word_a = {16'd0, b0, b1};
            end
            4'b1100: begin
                size_a = sz_2b;
                off_a = 2'd2;
                word_a = {16'd0, b2, b3};
            end
            4'b1111: begin
                size_a = sz_4b;
                word_a = {b0, b1, b2, b3};
            end
            // three and two byte holes need a second store
            4'b0111: begin
                two_pieces = 1'b1;
                off_a = 2'd2;
                word_a = {24'd0, b2};
                size_b = sz_2b;
                word_b = {16'd0, b0, b1};
            end
            4'b1110: begin
                two_pieces = 1'b1;
                off_a = 2'd1;
                word_a = {24'd0, b1};
                size_b = sz_2b;
                off_b = 2'd2;
                word_b = {16'd0, b2, b3};
            end
            4'b0110: begin
                two_pieces = 1'b1;
                off_a = 2'd1;
                word_a = {24'd0, b1};
                off_b = 2'd2;
                word_b = {24'd0, b2};
            end
            default: begin
                legal = 1'b0;
                size_a = sz_4b;
                word_a = {b0, b1, b2, b3};
            end
        endcase
    end

    assign addr_a = byte_base + {30'd0, off_a};
    assign addr_b = byte_base + {30'd0, off_b};

    // same data in both halves of the 64-bit bus
    assign data_a = {word_a, word_a};
    assign data_b = {word_b, word_b};

    a_legal_be: assert property (@(posedge clk) mem_write |-> legal)
        else $error("write with unsupported byte enables %b", byteenable);

endmodule

`default_nettype wire

/* request_ctrl.sv */
// L1.5 request FSM
`timescale 1ns/1ps
`default_nettype none

module request_ctrl (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_read,
    input  logic        mem_write,
    input  logic [29:0] mem_address,
    input  logic        load_done,
    input  logic        l15_ack,
    input  logic        two_pieces,
    input  logic [2:0]  size_a,
    input  logic [2:0]  size_b,
    input  logic [31:0] addr_a,
    input  logic [31:0] addr_b,
    input  logic [63:0] data_a,
    input  logic [63:0] data_b,
    output logic [31:0] byte_base,
    output logic        mem_waitrequest,
    output logic        l15_val,
    output logic [4:0]  l15_rqtype,
    output logic [2:0]  l15_size,
    output logic [39:0] l15_address,
    output logic [63:0] l15_data,
    output logic        l15_nc
);
    import l15_pkg::*;

    logic [2:0]  state;
    logic        capture;
    logic        complete;
    logic        is_read_q;
    logic        two_q;
    logic        nc_q;
    logic [2:0]  size_a_q;
    logic [2:0]  size_b_q;
    logic [31:0] addr_a_q;
    logic [31:0] addr_b_q;
    logic [63:0] data_a_q;
    logic [63:0] data_b_q;
    logic        on_b;

    assign byte_base = {mem_address, 2'b00};
    assign capture = (state == st_idle) && (mem_read || mem_write);

    // reads finish with the return and writes one cycle after the last ack
    assign complete = (state == st_done) || ((state == st_wait_load) && load_done);
    assign mem_waitrequest = (mem_read || mem_write) && !complete;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            l15_val <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (capture) begin
                        state <= st_issue_a;
                        l15_val <= 1'b1;
                    end
                end
                st_issue_a: begin
                    if (l15_ack) begin
                        if (is_read_q) begin
                            state <= st_wait_load;
                            l15_val <= 1'b0;
                        end else if (two_q) begin
                            // second piece goes out right behind the first
                            state <= st_issue_b;
                        end else begin
                            state <= st_done;
                            l15_val <= 1'b0;
                        end
                    end
                end
                st_issue_b: begin
                    if (l15_ack) begin
                        state <= st_done;
                        l15_val <= 1'b0;
                    end
                end
                st_wait_load: begin
                    if (load_done) begin
                        state <= st_idle;
                    end
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // request fields held from capture to the final ack
    always_ff @(posedge clk) begin
        if (capture) begin
            is_read_q <= mem_read;
            two_q <= two_pieces;
            nc_q <= mem_address[nc_bit];
            size_a_q <= mem_read ? sz_4b : size_a;
            addr_a_q <= mem_read ? byte_base : addr_a;
            data_a_q <= data_a;
            size_b_q <= size_b;
            addr_b_q <= addr_b;
            data_b_q <= data_b;
        end
    end

    assign on_b = (state == st_issue_b);
    assign l15_rqtype = is_read_q ? rq_load : rq_store;
    assign l15_size = on_b ? size_b_q : size_a_q;
    assign l15_address = {8'd0, on_b ? addr_b_q : addr_a_q};
    assign l15_data = on_b ? data_b_q : data_a_q;
    assign l15_nc = nc_q;

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (l15_val && !l15_ack) |=> (l15_val && $stable(l15_rqtype) && $stable(l15_size)
            && $stable(l15_address) && $stable(l15_data) && $stable(l15_nc)))
        else $error("L1.5 request dropped or changed before ack");

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_idle) |-> !l15_val)
        else $error("l15_val high while the request FSM is idle");

endmodule

`default_nettype wire

/* return_decode.sv */
// L1.5 return decode
`timescale 1ns/1ps
`default_nettype none

module return_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [29:0]            mem_address,
    input  logic                   l15_ret_val,
    input  logic [3:0]             l15_returntype,
    input  l15_pkg::l15_ret_word_t l15_ret_data_0,
    input  logic [63:0]            l15_ret_data_1,
    output logic                   load_done,
    output logic                   mem_readdatavalid,
    output logic [31:0]            mem_readdata,
    output logic                   l15_req_ack,
    output logic                   ao486_int
);
    import l15_pkg::*;

    logic [31:0] lane;
    logic        int_hit;

    // every return is taken the cycle it shows up
    assign l15_req_ack = l15_ret_val;

    assign load_done = l15_ret_val && (l15_returntype == ret_load);
    assign mem_readdatavalid = load_done;

    // returned line is big-endian and the word offset picks the 32-bit lane
    always_comb begin
        case (mem_address[1:0])
            2'd0: lane = l15_ret_data_0.ld.hi;
            2'd1: lane = l15_ret_data_0.ld.lo;
            2'd2: lane = l15_ret_data_1[63:32];
            default: lane = l15_ret_data_1[31:0];
        endcase
    end

    // back to little-endian for the core
    assign mem_readdata = {lane[7:0], lane[15:8], lane[23:16], lane[31:24]};

    assign int_hit = l15_ret_val && (l15_returntype == ret_int)
        && (l15_ret_data_0.intr.kind == int_wakeup);

    // one pulse per wakeup return
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ao486_int <= 1'b0;
        end else begin
            ao486_int <= int_hit;
        end
    end

endmodule

`default_nettype wire

/* ao486_l15_bridge.sv */
// ao486 Avalon to L1.5 bridge
`timescale 1ns/1ps
`default_nettype none

module ao486_l15_bridge (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [29:0] mem_address,
    input  logic [31:0] mem_writedata,
    input  logic [3:0]  mem_byteenable,
    input  logic        mem_read,
    input  logic        mem_write,
    output logic        mem_waitrequest,
    output logic        mem_readdatavalid,
    output logic [31:0] mem_readdata,
    output logic        l15_val,
    output logic [4:0]  l15_rqtype,
    output logic [2:0]  l15_size,
    output logic [39:0] l15_address,
    output logic [63:0] l15_data,
    output logic        l15_nc,
    input  logic        l15_ack,
    input  logic        l15_ret_val,
    input  logic [3:0]  l15_returntype,
    input  logic [63:0] l15_ret_data_0,
    input  logic [63:0] l15_ret_data_1,
    output logic        l15_req_ack,
    output logic        ao486_int
);

    logic [31:0] byte_base;
    logic        two_pieces;
    logic [2:0]  size_a;
    logic [2:0]  size_b;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    logic [63:0] data_a;
    logic [63:0] data_b;
    logic        load_done;

    store_splitter i_store_splitter (
        .clk        (clk),
        .mem_write  (mem_write),
        .byteenable (mem_byteenable),
        .writedata  (mem_writedata),
        .byte_base  (byte_base),
        .two_pieces (two_pieces),
        .size_a     (size_a),
        .size_b     (size_b),
        .addr_a     (addr_a),
        .addr_b     (addr_b),
        .data_a     (data_a),
        .data_b     (data_b)
    );

    request_ctrl i_request_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_address     (mem_address),
        .load_done       (load_done),
        .l15_ack         (l15_ack),
        .two_pieces      (two_pieces),
        .size_a          (size_a),
        .size_b          (size_b),
        .addr_a          (addr_a),
        .addr_b          (addr_b),
        .data_a          (data_a),
        .data_b          (data_b),
        .byte_base       (byte_base),
        .mem_waitrequest (mem_waitrequest),
        .l15_val         (l15_val),
        .l15_rqtype      (l15_rqtype),
        .l15_size        (l15_size),
        .l15_address     (l15_address),
        .l15_data        (l15_data),
        .l15_nc          (l15_nc)
    );

    return_decode i_return_decode (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_address       (mem_address),
        .l15_ret_val       (l15_ret_val),
        .l15_returntype    (l15_returntype),
        .l15_ret_data_0    (l15_ret_data_0),
        .l15_ret_data_1    (l15_ret_data_1),
        .load_done         (load_done),
        .mem_readdatavalid (mem_readdatavalid),
        .mem_readdata      (mem_readdata),
        .l15_req_ack       (l15_req_ack),
        .ao486_int         (ao486_int)
    );

endmodule

`default_nettype wire

/* tb_l15_model.sv */
// Behavioral L1.5 cache
`timescale 1ns/1ps
`default_nettype none

module tb_l15_model (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        l15_val,
    input  wire logic [4:0]  l15_rqtype,
    input  wire logic [2:0]  l15_size,
    input  wire logic [39:0] l15_address,
    input  wire logic [63:0] l15_data,
    output logic             l15_ack,
    output logic             l15_ret_val,
    output logic [3:0]       l15_returntype,
    output logic [63:0]      l15_ret_data_0,
    output logic [63:0]      l15_ret_data_1,
    input  wire logic        inj,
    input  wire logic [3:0]  inj_type,
    input  wire logic [1:0]  inj_kind
);
    import l15_pkg::*;

    logic [7:0]    mem [256];
    int            ack_wait;
    int            load_wait;
    logic [7:0]    load_base;
    logic          inj_q;
    logic [3:0]    inj_type_q;
    logic [1:0]    inj_kind_q;
    l15_ret_word_t w;

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 37 + 90);
    endfunction

    // big-endian store of 1, 2 or 4 bytes
    task automatic apply_store();
        int n;
        logic [7:0] idx;
        n = (l15_size == sz_1b) ? 1 : (l15_size == sz_2b) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            idx = l15_address[7:0] + 8'(i);
            mem[idx] = l15_data[(n - 1 - i) * 8 +: 8];
        end
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_byte(i);
        end
        l15_ack = 1'b0;
        l15_ret_val = 1'b0;
        l15_returntype = ret_st_ack;
        l15_ret_data_0 = 64'd0;
        l15_ret_data_1 = 64'd0;
    end

    always @(posedge clk) begin
        inj_q <= inj;
        inj_type_q <= inj_type;
        inj_kind_q <= inj_kind;
    end

    always @(negedge clk) begin
        l15_ack <= 1'b0;
        l15_ret_val <= 1'b0;
        l15_ret_data_0 <= 64'd0;
        l15_ret_data_1 <= 64'd0;
        if (!rst_n) begin
            ack_wait = -1;
            load_wait = -1;
        end else begin
            if (load_wait > 0) begin
                load_wait--;
                if (load_wait == 0) begin
                    w.ld.hi = {mem[load_base], mem[load_base + 8'd1],
                        mem[load_base + 8'd2], mem[load_base + 8'd3]};
                    w.ld.lo = {mem[load_base + 8'd4], mem[load_base + 8'd5],
                        mem[load_base + 8'd6], mem[load_base + 8'd7]};
                    l15_ret_val <= 1'b1;
                    l15_returntype <= ret_load;
                    l15_ret_data_0 <= w;
                    l15_ret_data_1 <= {mem[load_base + 8'd8], mem[load_base + 8'd9],
                        mem[load_base + 8'd10], mem[load_base + 8'd11],
                        mem[load_base + 8'd12], mem[load_base + 8'd13],
                        mem[load_base + 8'd14], mem[load_base + 8'd15]};
                    load_wait = -1;
                end
            end else if (inj_q) begin
                w = 64'd0;
                w.intr.kind = inj_kind_q;
                l15_ret_val <= 1'b1;
                l15_returntype <= inj_type_q;
                l15_ret_data_0 <= w;
            end
            if (l15_val) begin
                if (ack_wait < 0) begin
                    ack_wait = int'($urandom_range(3, 0));
                end
                if (ack_wait == 0) begin
                    l15_ack <= 1'b1;
                    ack_wait = -1;
                    if (l15_rqtype == rq_store) begin
                        apply_store();
                    end else begin
                        load_wait = int'($urandom_range(4, 1));
                        load_base = l15_address[7:0] & 8'hf0;
                    end
                end else begin
                    ack_wait--;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_top.sv */
// Bridge testbench
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import l15_pkg::*;

    localparam int n_ops = 200;
    localparam int limit_ns = n_ops * 20 * 4;

    logic clk = 1'b0;
    logic rst_n;
    logic [29:0] mem_address;
    logic [31:0] mem_writedata;
    logic [3:0] mem_byteenable;
    logic mem_read;
    logic mem_write;
    logic mem_waitrequest;
    logic mem_readdatavalid;
    logic [31:0] mem_readdata;
    logic l15_val;
    logic [4:0] l15_rqtype;
    logic [2:0] l15_size;
    logic [39:0] l15_address;
    logic [63:0] l15_data;
    logic l15_nc;
    logic l15_ack;
    logic l15_ret_val;
    logic [3:0] l15_returntype;
    logic [63:0] l15_ret_data_0;
    logic [63:0] l15_ret_data_1;
    logic l15_req_ack;
    logic ao486_int;
    logic inj;
    logic [3:0] inj_type;
    logic [1:0] inj_kind;

    int mismatch_count = 0;
    int other_count = 0;
    logic started = 1'b0;
    logic cmd_done;
    logic [1:0] ack_count;
    logic [1:0] exp_n;
    logic [2:0] exp_size [2];
    logic [39:0] exp_addr [2];
    logic [63:0] exp_data [2];
    logic [7:0] ref_mem [256];
    logic [7:0] rb;
    logic [31:0] exp_rd;
    logic int_now;
    logic [3:0] legal_be [10] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011,
        4'b1100, 4'b1111, 4'b0111, 4'b1110, 4'b0110};

    ao486_l15_bridge i_ao486_l15_bridge (.*);

    tb_l15_model i_l15_model (.*);

    always #2 clk = ~clk;

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 37 + 90);
    endfunction

    // piece bytes in address order and right-aligned
    function automatic logic [31:0] piece_word(input logic [31:0] d, input int lane,
            input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v = {v[23:0], d[(lane + i) * 8 +: 8]};
        end
        return v;
    endfunction

    task automatic set_piece(input int k, input int lane, input int n);
        logic [31:0] v;
        v = piece_word(mem_writedata, lane, n);
        exp_size[k] = (n == 1) ? sz_1b : (n == 2) ? sz_2b : sz_4b;
        exp_addr[k] = {8'd0, mem_address, 2'b00} + 40'(lane);
        exp_data[k] = {v, v};
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (!cmd_done);
        mem_read = 1'b0;
        mem_write = 1'b0;
        @(negedge clk);
    endtask

    task automatic write_word(input logic [29:0] a, input logic [31:0] d,
            input logic [3:0] be);
        mem_address = a;
        mem_writedata = d;
        mem_byteenable = be;
        exp_n = 2'd1;
        case (be)
            4'b0010: set_piece(0, 1, 1);
            4'b0100: set_piece(0, 2, 1);
            4'b1000: set_piece(0, 3, 1);
            4'b0011: set_piece(0, 0, 2);
            4'b1100: set_piece(0, 2, 2);
            4'b1111: set_piece(0, 0, 4);
            4'b0111: begin
                exp_n = 2'd2;
                set_piece(0, 2, 1);
                set_piece(1, 0, 2);
            end
            4'b1110: begin
                exp_n = 2'd2;
                set_piece(0, 1, 1);
                set_piece(1, 2, 2);
            end
            4'b0110: begin
                exp_n = 2'd2;
                set_piece(0, 1, 1);
                set_piece(1, 2, 1);
            end
            default: set_piece(0, 0, 1);
        endcase
        started = 1'b1;
        mem_write = 1'b1;
        wait_done();
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                ref_mem[rb + 8'(i)] = d[i * 8 +: 8];
            end
        end
    endtask

    task automatic read_word(input logic [29:0] a);
        mem_address = a;
        started = 1'b1;
        mem_read = 1'b1;
        wait_done();
    endtask

    task automatic inject(input logic [3:0] t, input logic [1:0] k);
        started = 1'b1;
        inj = 1'b1;
        inj_type = t;
        inj_kind = k;
        @(negedge clk);
        inj = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // expected read data as little-endian bytes of the reference memory
    assign rb = {mem_address[5:0], 2'b00};
    assign exp_rd = {ref_mem[rb + 8'd3], ref_mem[rb + 8'd2], ref_mem[rb + 8'd1], ref_mem[rb]};
    assign int_now = l15_ret_val && (l15_returntype == ret_int)
        && (l15_ret_data_0[17:16] == int_wakeup);

    always @(posedge clk) begin
        cmd_done <= (mem_read || mem_write) && !mem_waitrequest;
        if (!rst_n || !mem_write) begin
            ack_count <= 2'd0;
        end else if (l15_val && l15_ack) begin
            ack_count <= ack_count + 2'd1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!l15_val && !mem_waitrequest && !mem_readdatavalid && !ao486_int))
        else begin
            other_count++;
            $display("outputs not quiet after reset at %0t", $time);
        end

    a_store_piece: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_write && l15_val && l15_ack) |-> (ack_count < exp_n && l15_rqtype == rq_store
            && l15_size == exp_size[ack_count[0]] && l15_address == exp_addr[ack_count[0]]
            && l15_data == exp_data[ack_count[0]] && l15_nc == mem_address[nc_bit]))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: store piece %0d be %b", $time, ack_count, mem_byteenable);
        end

    a_write_end: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_write && !mem_waitrequest) |-> (ack_count == exp_n))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: write completed after %0d acks", $time, ack_count);
        end

    a_load_req: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read && l15_val && l15_ack) |-> (l15_rqtype == rq_load && l15_size == sz_4b
            && l15_address == {8'd0, mem_address, 2'b00} && l15_nc == mem_address[nc_bit]))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: load request fields", $time);
        end

    a_read_end: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read && !mem_waitrequest) |-> mem_readdatavalid)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: read completed without readdatavalid", $time);
        end

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        mem_readdatavalid |-> (mem_read && !mem_waitrequest && mem_readdata == exp_rd))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: readdata %h expected %h", $time, mem_readdata, exp_rd);
        end

    a_int_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ao486_int == $past(int_now))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: ao486_int is %b", $time, ao486_int);
        end

    a_ret_ack: assert property (@(posedge clk) disable iff (!rst_n)
        l15_req_ack == l15_ret_val)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: l15_req_ack differs from l15_ret_val", $time);
        end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (l15_val && !l15_ack) |=> (l15_val && $stable(l15_rqtype) && $stable(l15_size)
            && $stable(l15_address) && $stable(l15_data) && $stable(l15_nc)))
        else begin
            other_count++;
            $display("request was dropped or changed before its ack at %0t", $time);
        end

    initial begin
        #(limit_ns);
        other_count++;
        $display("timeout: the run did not finish in %0d ns", limit_ns);
        finish_run();
    end

    initial begin
        int r;
        logic [29:0] a;
        void'($urandom(32'hbc33));
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_byte(i);
        end
        rst_n = 1'b0;
        mem_address = 30'd0;
        mem_writedata = 32'd0;
        mem_byteenable = 4'b0000;
        mem_read = 1'b0;
        mem_write = 1'b0;
        inj = 1'b0;
        inj_type = ret_int;
        inj_kind = 2'd0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        for (int op = 0; op < n_ops; op++) begin
            r = int'($urandom_range(9, 0));
            a = 30'($urandom_range(63, 0));
            a[29] = 1'($urandom_range(1, 0));
            if (r < 5) begin
                write_word(a, $urandom, legal_be[$urandom_range(9, 0)]);
            end else if (r < 8) begin
                read_word(a);
            end else if (r == 8) begin
                inject(ret_int, 2'($urandom_range(3, 0)));
            end else begin
                inject(ret_st_ack, int_wakeup);
            end
        end
        repeat (5) @(negedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

/* tb.f */
l15_pkg.sv
store_splitter.sv
request_ctrl.sv
return_decode.sv
ao486_l15_bridge.sv
tb_l15_model.sv
tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
